// ==== rtl/soc_ic_pkg.sv ====
// SoC interconnect package with memory map, TCDM bus bundles and encodings
package soc_ic_pkg;

    //////////////////////////////////////////////////
    // Bus widths and sizes
    //////////////////////////////////////////////////

    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int BE_WIDTH      = DATA_WIDTH / 8;
    localparam int NR_MASTERS    = 3;
    localparam int NR_L2_BANKS   = 2;
    localparam int L2_BANK_WORDS = 256;

    // Targets seen by each master: the L2 banks first, then the APB bridge
    localparam int NR_TARGETS = NR_L2_BANKS + 1;
    localparam int TGT_IDX_W  = $clog2(NR_TARGETS);
    localparam int TGT_PERIPH = NR_L2_BANKS;

    // Word interleaving, byte address bit 2 picks the bank
    localparam int BANK_SEL_BIT = 2;
    localparam int BANK_IDX_W   = $clog2(NR_L2_BANKS);

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////

    localparam logic [ADDR_WIDTH-1:0] L2_START_ADDR     = 32'h1C00_0000;
    localparam logic [ADDR_WIDTH-1:0] L2_END_ADDR       = 32'h1C00_07FF;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_START_ADDR = 32'h1A10_0000;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_END_ADDR   = 32'h1A10_FFFF;

    // Upper 12 address bits for the legacy data-port alias
    localparam logic [11:0] ALIAS_PREFIX = 12'h000;
    localparam logic [11:0] L2_PREFIX    = 12'h1C0;

    //////////////////////////////////////////////////
    // Encodings and bundles
    //////////////////////////////////////////////////

    typedef enum logic {
        OPC_OK  = 1'b0,
        OPC_ERR = 1'b1
    } rsp_opc_e;

    typedef enum logic [1:0] {
        REGION_L2     = 2'd0,
        REGION_PERIPH = 2'd1,
        REGION_NONE   = 2'd2
    } region_e;

    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

    // Request side, wen low means write
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] add;
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } tcdm_req_t;

    // Response side
    typedef struct packed {
        logic                  gnt;
        logic                  r_valid;
        logic [DATA_WIDTH-1:0] r_rdata;
        rsp_opc_e              r_opc;
    } tcdm_rsp_t;

endpackage

// ==== rtl/tcdm_master_port.sv ====
// Master-side port with address alias, region decode, routing and response return
`timescale 1ns/1ps

module tcdm_master_port import soc_ic_pkg::*; #(
    parameter bit ALIAS_EN = 1'b0
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  tcdm_req_t req_i,
    output tcdm_rsp_t rsp_o,
    output tcdm_req_t tgt_req_o [NR_TARGETS],
    input  tcdm_rsp_t tgt_rsp_i [NR_TARGETS]
);

    logic [ADDR_WIDTH-1:0] add_mapped;
    region_e               region;
    logic [TGT_IDX_W-1:0]  tgt_idx;
    logic                  gnt;
    logic [NR_TARGETS-1:0] tgt_rvalid;
    logic                  rvalid_sel;

    // Outstanding response bookkeeping
    logic                  pend_q;
    logic                  err_q;
    logic [TGT_IDX_W-1:0]  own_q;

    //////////////////////////////////////////////////
    // Alias and decode
    //////////////////////////////////////////////////

    // Prefix 0x000 folds onto the L2 prefix on the aliased port
    always_comb begin
        add_mapped = req_i.add;
        if (ALIAS_EN && req_i.add[ADDR_WIDTH-1 -: $bits(ALIAS_PREFIX)] == ALIAS_PREFIX) begin
            add_mapped[ADDR_WIDTH-1 -: $bits(L2_PREFIX)] = L2_PREFIX;
        end
    end

    // One rule per region, the peripheral rule covers the whole APB window
    always_comb begin
        if (add_mapped >= L2_START_ADDR && add_mapped <= L2_END_ADDR) begin
            region  = REGION_L2;
            tgt_idx = TGT_IDX_W'(add_mapped[BANK_SEL_BIT +: BANK_IDX_W]);
        end else if (add_mapped >= PERIPH_START_ADDR && add_mapped <= PERIPH_END_ADDR) begin
            region  = REGION_PERIPH;
            tgt_idx = TGT_IDX_W'(TGT_PERIPH);
        end else begin
            region  = REGION_NONE;
            tgt_idx = '0;
        end
    end

    //////////////////////////////////////////////////
    // Request routing
    //////////////////////////////////////////////////

    // Every target sees the payload, only the decoded one sees req
    always_comb begin
        for (int t = 0; t < NR_TARGETS; t++) begin
            tgt_req_o[t]     = req_i;
            tgt_req_o[t].add = add_mapped;
            tgt_req_o[t].req = req_i.req && (region != REGION_NONE)
                               && (tgt_idx == TGT_IDX_W'(t));
            tgt_rvalid[t]    = tgt_rsp_i[t].r_valid;
        end
    end

    // Unmapped accesses are accepted right away
    assign gnt = (region == REGION_NONE) ? req_i.req : tgt_rsp_i[tgt_idx].gnt;

    assign rvalid_sel = pend_q && tgt_rvalid[own_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q <= 1'b0;
            err_q  <= 1'b0;
            own_q  <= '0;
        end else begin
            // Error beat goes out on the cycle after the grant
            err_q <= gnt && (region == REGION_NONE);
            // A new grant wins over the retiring response
            if (gnt && region != REGION_NONE) begin
                pend_q <= 1'b1;
                own_q  <= tgt_idx;
            end else if (rvalid_sel) begin
                pend_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Response return
    //////////////////////////////////////////////////

    always_comb begin
        rsp_o     = '0;
        rsp_o.gnt = gnt;
        if (err_q) begin
            rsp_o.r_valid = 1'b1;
            rsp_o.r_opc   = OPC_ERR;
        end else if (rvalid_sel) begin
            rsp_o.r_valid = 1'b1;
            rsp_o.r_rdata = tgt_rsp_i[own_q].r_rdata;
            rsp_o.r_opc   = tgt_rsp_i[own_q].r_opc;
        end
    end

    // A response from any arbiter must belong to our outstanding access
    a_rvalid_owned : assert property (@(posedge clk_i) disable iff (reset_i)
        (|tgt_rvalid) |-> (pend_q && tgt_rvalid[own_q]))
        else $error("r_valid without outstanding request");

endmodule

// ==== rtl/tcdm_rr_arbiter.sv ====
// Round-robin arbiter sharing one target among several TCDM requesters
`timescale 1ns/1ps

module tcdm_rr_arbiter import soc_ic_pkg::*; #(
    parameter int NR_REQ = 3
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  tcdm_req_t             req_i [NR_REQ],
    output tcdm_rsp_t             rsp_o [NR_REQ],
    output tcdm_req_t             tgt_req_o,
    input  logic                  tgt_ready_i,
    input  logic                  tgt_rvalid_i,
    input  logic [DATA_WIDTH-1:0] tgt_rdata_i,
    input  rsp_opc_e              tgt_opc_i
);

    typedef logic [$clog2(NR_REQ)-1:0] idx_t;

    idx_t              ptr_q;
    idx_t              owner_q;
    idx_t              win_idx;
    logic              win_vld;
    logic              grant_vld;
    logic [NR_REQ-1:0] gnt_vec;
    logic [NR_REQ-1:0] req_vec;

    //////////////////////////////////////////////////
    // Winner search
    //////////////////////////////////////////////////

    // Search starts at the pointer, which sits one past the last winner
    always_comb begin
        int unsigned cand;
        win_vld = 1'b0;
        win_idx = '0;
        for (int off = 0; off < NR_REQ; off++) begin
            cand = (int'(ptr_q) + off) % NR_REQ;
            if (!win_vld && req_i[cand].req) begin
                win_vld = 1'b1;
                win_idx = idx_t'(cand);
            end
        end
    end

    // Busy target holds everyone off
    assign grant_vld = win_vld && tgt_ready_i;

    always_comb begin
        tgt_req_o     = req_i[win_idx];
        tgt_req_o.req = grant_vld;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q   <= '0;
            owner_q <= '0;
        end else if (grant_vld) begin
            owner_q <= win_idx;
            ptr_q   <= (win_idx == idx_t'(NR_REQ - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Grant and response fan-out
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NR_REQ; i++) begin
            req_vec[i]   = req_i[i].req;
            gnt_vec[i]   = grant_vld && (win_idx == idx_t'(i));
            rsp_o[i]     = '0;
            rsp_o[i].gnt = gnt_vec[i];
            // Read data only toward the registered owner
            if (tgt_rvalid_i && owner_q == idx_t'(i)) begin
                rsp_o[i].r_valid = 1'b1;
                rsp_o[i].r_rdata = tgt_rdata_i;
                rsp_o[i].r_opc   = tgt_opc_i;
            end
        end
    end

    // Back-to-back grants to one requester only while nobody else waits
    a_rr_fair : assert property (@(posedge clk_i) disable iff (reset_i)
        (grant_vld && $past(grant_vld) && win_idx == $past(win_idx))
        |-> (req_vec == gnt_vec))
        else $error("requester granted twice in a row while another waited");

endmodule

// ==== rtl/l2_sram_bank.sv ====
// Word-wide L2 SRAM bank with byte enables and single-cycle read response
`timescale 1ns/1ps

module l2_sram_bank import soc_ic_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  tcdm_req_t             req_i,
    output logic                  ready_o,
    output logic                  rvalid_o,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output rsp_opc_e              opc_o
);

    logic [DATA_WIDTH-1:0]            mem_q [L2_BANK_WORDS];
    logic [$clog2(L2_BANK_WORDS)-1:0] word_idx;
    logic [DATA_WIDTH-1:0]            rdata_q;
    logic                             rvalid_q;

    // Word index sits just above the bank-select bit
    assign word_idx = req_i.add[BANK_SEL_BIT + BANK_IDX_W +: $clog2(L2_BANK_WORDS)];

    // Byte-lane writes, read data is zero for writes
    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (!req_i.wen) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (req_i.be[b]) begin
                        mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
                rdata_q <= '0;
            end else begin
                rdata_q <= mem_q[word_idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    // SRAM never stalls and never faults
    assign ready_o  = 1'b1;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign opc_o    = OPC_OK;

endmodule

// ==== rtl/apb_master_bridge.sv ====
// Bridge turning a granted TCDM request into one APB setup and access transfer
`timescale 1ns/1ps

module apb_master_bridge import soc_ic_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  tcdm_req_t             req_i,
    output logic                  ready_o,
    output logic                  rvalid_o,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output rsp_opc_e              opc_o,
    output logic [ADDR_WIDTH-1:0] paddr_o,
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [DATA_WIDTH-1:0] pwdata_o,
    input  logic [DATA_WIDTH-1:0] prdata_i,
    input  logic                  pready_i,
    input  logic                  pslverr_i
);

    apb_state_e            state_q;
    logic                  rvalid_q;
    rsp_opc_e              opc_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    // Latched transfer
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  write_q;

    //////////////////////////////////////////////////
    // Transfer FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= APB_IDLE;
            rvalid_q <= 1'b0;
            opc_q    <= OPC_OK;
        end else begin
            rvalid_q <= 1'b0;
            case (state_q)
                APB_IDLE: begin
                    if (req_i.req) begin
                        state_q <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    state_q <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    // Slave ends the transfer and the response goes out next cycle
                    if (pready_i) begin
                        state_q  <= APB_IDLE;
                        rvalid_q <= 1'b1;
                        opc_q    <= pslverr_i ? OPC_ERR : OPC_OK;
                    end
                end
                default: begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (state_q == APB_IDLE && req_i.req) begin
            addr_q  <= req_i.add;
            wdata_q <= req_i.wdata;
            write_q <= !req_i.wen;
        end
        if (state_q == APB_ACCESS && pready_i) begin
            rdata_q <= (write_q || pslverr_i) ? '0 : prdata_i;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign ready_o   = (state_q == APB_IDLE);
    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);
    assign paddr_o   = addr_q;
    assign pwrite_o  = write_q;
    assign pwdata_o  = wdata_q;
    assign rvalid_o  = rvalid_q;
    assign rdata_o   = rdata_q;
    assign opc_o     = opc_q;

    // The arbiter may only forward a request while the bridge is idle
    a_req_when_idle : assert property (@(posedge clk_i) disable iff (reset_i)
        req_i.req |-> ready_o)
        else $error("request reached the bridge while busy");

endmodule

// ==== rtl/soc_interconnect_top.sv ====
// SoC memory interconnect joining three TCDM masters to two L2 banks and APB
`timescale 1ns/1ps

module soc_interconnect_top import soc_ic_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  tcdm_req_t             mst_req_i [NR_MASTERS],
    output tcdm_rsp_t             mst_rsp_o [NR_MASTERS],
    output logic [ADDR_WIDTH-1:0] paddr_o,
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [DATA_WIDTH-1:0] pwdata_o,
    input  logic [DATA_WIDTH-1:0] prdata_i,
    input  logic                  pready_i,
    input  logic                  pslverr_i
);

    // Master-port side, indexed [master][target]
    tcdm_req_t mp_req [NR_MASTERS][NR_TARGETS];
    tcdm_rsp_t mp_rsp [NR_MASTERS][NR_TARGETS];

    // Arbiter side, indexed [target][master]
    tcdm_req_t arb_req [NR_TARGETS][NR_MASTERS];
    tcdm_rsp_t arb_rsp [NR_TARGETS][NR_MASTERS];

    // Target side, banks first then the bridge
    tcdm_req_t             tgt_req    [NR_TARGETS];
    logic                  tgt_ready  [NR_TARGETS];
    logic                  tgt_rvalid [NR_TARGETS];
    logic [DATA_WIDTH-1:0] tgt_rdata  [NR_TARGETS];
    rsp_opc_e              tgt_opc    [NR_TARGETS];

    //////////////////////////////////////////////////
    // Master ports, alias only on the FC data port
    //////////////////////////////////////////////////

    for (genvar m = 0; m < NR_MASTERS; m++) begin : g_mst
        tcdm_master_port #(
            .ALIAS_EN (m == 0)
        ) i_master_port (
            .clk_i,
            .reset_i,
            .req_i     (mst_req_i[m]),
            .rsp_o     (mst_rsp_o[m]),
            .tgt_req_o (mp_req[m]),
            .tgt_rsp_i (mp_rsp[m])
        );

        // Transpose between master and target views
        for (genvar t = 0; t < NR_TARGETS; t++) begin : g_xpose
            assign arb_req[t][m] = mp_req[m][t];
            assign mp_rsp[m][t]  = arb_rsp[t][m];
        end
    end

    //////////////////////////////////////////////////
    // One arbiter per target
    //////////////////////////////////////////////////

    for (genvar t = 0; t < NR_TARGETS; t++) begin : g_arb
        tcdm_rr_arbiter #(
            .NR_REQ (NR_MASTERS)
        ) i_arbiter (
            .clk_i,
            .reset_i,
            .req_i        (arb_req[t]),
            .rsp_o        (arb_rsp[t]),
            .tgt_req_o    (tgt_req[t]),
            .tgt_ready_i  (tgt_ready[t]),
            .tgt_rvalid_i (tgt_rvalid[t]),
            .tgt_rdata_i  (tgt_rdata[t]),
            .tgt_opc_i    (tgt_opc[t])
        );
    end

    // Interleaved L2 banks
    for (genvar b = 0; b < NR_L2_BANKS; b++) begin : g_bank
        l2_sram_bank i_bank (
            .clk_i,
            .reset_i,
            .req_i    (tgt_req[b]),
            .ready_o  (tgt_ready[b]),
            .rvalid_o (tgt_rvalid[b]),
            .rdata_o  (tgt_rdata[b]),
            .opc_o    (tgt_opc[b])
        );
    end

    // Peripheral bus
    apb_master_bridge i_apb_bridge (
        .clk_i,
        .reset_i,
        .req_i     (tgt_req[TGT_PERIPH]),
        .ready_o   (tgt_ready[TGT_PERIPH]),
        .rvalid_o  (tgt_rvalid[TGT_PERIPH]),
        .rdata_o   (tgt_rdata[TGT_PERIPH]),
        .opc_o     (tgt_opc[TGT_PERIPH]),
        .paddr_o,
        .psel_o,
        .penable_o,
        .pwrite_o,
        .pwdata_o,
        .prdata_i,
        .pready_i,
        .pslverr_i
    );

endmodule

// ==== bench/apb_periph_model.sv ====
// APB register-file peripheral with random wait states and an error window
`timescale 1ns/1ps

module apb_periph_model import soc_ic_pkg::*; #(
    parameter int unsigned SEED = 1
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [ADDR_WIDTH-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [DATA_WIDTH-1:0] pwdata_i,
    output logic [DATA_WIDTH-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic [DATA_WIDTH-1:0] regs_q [16];
    logic [1:0]            wait_q;
    logic                  in_range;
    logic [3:0]            reg_idx;

    // Offsets 0x00 to 0x3C hold registers, anything above faults
    assign in_range  = (paddr_i[15:6] == '0);
    assign reg_idx   = paddr_i[5:2];
    assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
    assign pslverr_o = pready_o && !in_range;
    assign prdata_o  = (pready_o && in_range && !pwrite_i) ? regs_q[reg_idx] : '0;

    // Wait states drawn at setup, counted down during access
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk_i);
            if (reset_i) begin
                wait_q <= 2'd0;
            end else if (psel_i && !penable_i) begin
                wait_q <= 2'($urandom_range(3, 0));
            end else if (penable_i && wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else if (pready_o && in_range && pwrite_i) begin
                regs_q[reg_idx] <= pwdata_i;
            end
        end
    end

endmodule

// ==== bench/tb_soc_interconnect.sv ====
// Testbench running a stimulus table through the SoC memory interconnect
`timescale 1ns/1ps

module tb_soc_interconnect import soc_ic_pkg::*; ();

    localparam time CLK_HALF         = 10ns;
    localparam time DRIVE_DLY        = 1ns;
    localparam int  NR_ENTRIES       = 24;
    localparam int  CYCLES_PER_ENTRY = 40;
    localparam int  WATCHDOG_CYCLES  = NR_ENTRIES * CYCLES_PER_ENTRY + 10;

    // One access with grp marking three entries issued together
    typedef struct packed {
        logic [1:0]            master;
        logic                  wen;
        logic [ADDR_WIDTH-1:0] add;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] exp_rdata;
        rsp_opc_e              exp_opc;
        logic                  grp;
    } tb_entry_t;

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    // master, wen, add, wdata, be, expected rdata, expected opcode, group
    localparam tb_entry_t STIM_TABLE [NR_ENTRIES] = '{
        '{2'd0, 1'b0, 32'h1C00_0000, 32'h1111_2222, 4'hF, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd0, 1'b1, 32'h1C00_0000, 32'h0000_0000, 4'hF, 32'h1111_2222, OPC_OK,  1'b0},
        '{2'd1, 1'b0, 32'h1C00_0004, 32'hAABB_CCDD, 4'hF, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd1, 1'b0, 32'h1C00_0004, 32'h0000_5500, 4'h2, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd2, 1'b1, 32'h1C00_0004, 32'h0000_0000, 4'hF, 32'hAABB_55DD, OPC_OK,  1'b0},
        '{2'd2, 1'b0, 32'h1C00_0010, 32'h5A5A_A5A5, 4'hF, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd0, 1'b1, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h5A5A_A5A5, OPC_OK,  1'b0},
        '{2'd1, 1'b1, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h0000_0000, OPC_ERR, 1'b0},
        '{2'd0, 1'b0, 32'h1A10_0008, 32'hCAFE_F00D, 4'hF, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd2, 1'b1, 32'h1A10_0008, 32'h0000_0000, 4'hF, 32'hCAFE_F00D, OPC_OK,  1'b0},
        '{2'd1, 1'b0, 32'h1A10_003C, 32'h0BAD_BEEF, 4'hF, 32'h0000_0000, OPC_OK,  1'b0},
        '{2'd1, 1'b1, 32'h1A10_003C, 32'h0000_0000, 4'hF, 32'h0BAD_BEEF, OPC_OK,  1'b0},
        '{2'd0, 1'b1, 32'h1A10_0040, 32'h0000_0000, 4'hF, 32'h0000_0000, OPC_ERR, 1'b0},
        '{2'd2, 1'b0, 32'h3000_0000, 32'h1234_5678, 4'hF, 32'h0000_0000, OPC_ERR, 1'b0},
        '{2'd1, 1'b1, 32'h3000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, OPC_ERR, 1'b0},
        '{2'd0, 1'b0, 32'h1C00_0100, 32'hA0A0_0000, 4'hF, 32'h0000_0000, OPC_OK,  1'b1},
        '{2'd1, 1'b0, 32'h1C00_0108, 32'hB1B1_1111, 4'hF, 32'h0000_0000, OPC_OK,  1'b1},
        '{2'd2, 1'b0, 32'h1C00_0110, 32'hC2C2_2222, 4'hF, 32'h0000_0000, OPC_OK,  1'b1},
        '{2'd0, 1'b1, 32'h1C00_0100, 32'h0000_0000, 4'hF, 32'hA0A0_0000, OPC_OK,  1'b1},
        '{2'd1, 1'b1, 32'h1C00_0108, 32'h0000_0000, 4'hF, 32'hB1B1_1111, OPC_OK,  1'b1},
        '{2'd2, 1'b1, 32'h1C00_0110, 32'h0000_0000, 4'hF, 32'hC2C2_2222, OPC_OK,  1'b1},
        '{2'd0, 1'b1, 32'h1C00_0000, 32'h0000_0000, 4'hF, 32'h1111_2222, OPC_OK,  1'b1},
        '{2'd1, 1'b1, 32'h1C00_0004, 32'h0000_0000, 4'hF, 32'hAABB_55DD, OPC_OK,  1'b1},
        '{2'd2, 1'b1, 32'h1A10_0008, 32'h0000_0000, 4'hF, 32'hCAFE_F00D, OPC_OK,  1'b1}
    };

    logic                  clk;
    logic                  reset;
    tcdm_req_t             mst_req [NR_MASTERS];
    tcdm_rsp_t             mst_rsp [NR_MASTERS];
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    int                    error_count;

    soc_interconnect_top i_dut (
        .clk_i     (clk),
        .reset_i   (reset),
        .mst_req_i (mst_req),
        .mst_rsp_o (mst_rsp),
        .paddr_o   (paddr),
        .psel_o    (psel),
        .penable_o (penable),
        .pwrite_o  (pwrite),
        .pwdata_o  (pwdata),
        .prdata_i  (prdata),
        .pready_i  (pready),
        .pslverr_i (pslverr)
    );

    apb_periph_model #(
        .SEED (76253)
    ) i_periph (
        .clk_i     (clk),
        .reset_i   (reset),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #(CLK_HALF) clk = !clk;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stop_with_failure();
        error_count++;
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_opc(input string name, input rsp_opc_e got, input rsp_opc_e exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
            stop_with_failure();
        end
    endtask

    // Everything outside the APB window answers exactly one cycle after the grant
    function automatic bit fixed_latency(input logic [ADDR_WIDTH-1:0] add);
        return !(add >= PERIPH_START_ADDR && add <= PERIPH_END_ADDR);
    endfunction

    // No handshake or APB activity may appear while nobody requests
    task automatic check_bus_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (mst_rsp[m].gnt || mst_rsp[m].r_valid) begin
                    $display("Master %0d saw gnt or r_valid before any request", m);
                    stop_with_failure();
                end
            end
            if (psel || penable) begin
                $display("APB psel or penable went high before any request");
                stop_with_failure();
            end
            @(posedge clk);
            #(DRIVE_DLY);
        end
    endtask

    //////////////////////////////////////////////////
    // Access sequencing
    //////////////////////////////////////////////////

    // Issue count entries at once and then wait for every grant and response
    task automatic run_batch(input int first, input int count);
        logic [NR_MASTERS-1:0] granted;
        logic [NR_MASTERS-1:0] done;
        logic [NR_MASTERS-1:0] all_mask;
        int                    gnt_cycle [NR_MASTERS];
        tb_entry_t             e;
        int                    m;
        int                    cycles;
        granted  = '0;
        done     = '0;
        all_mask = '0;
        cycles   = 0;
        for (int k = 0; k < count; k++) begin
            e                 = STIM_TABLE[first + k];
            m                 = int'(e.master);
            all_mask[k]       = 1'b1;
            gnt_cycle[k]      = 0;
            mst_req[m].req    = 1'b1;
            mst_req[m].add    = e.add;
            mst_req[m].wen    = e.wen;
            mst_req[m].wdata  = e.wdata;
            mst_req[m].be     = e.be;
        end
        while (done != all_mask) begin
            @(negedge clk);
            cycles++;
            for (int k = 0; k < count; k++) begin
                e = STIM_TABLE[first + k];
                m = int'(e.master);
                if (granted[k] && !done[k] && mst_rsp[m].r_valid) begin
                    check_word($sformatf("mst_rsp_o[%0d].r_rdata", m),
                               mst_rsp[m].r_rdata, e.exp_rdata);
                    check_opc($sformatf("mst_rsp_o[%0d].r_opc", m),
                              mst_rsp[m].r_opc, e.exp_opc);
                    done[k] = 1'b1;
                end else if (granted[k] && !done[k] && fixed_latency(e.add)
                             && cycles > gnt_cycle[k]) begin
                    $display("Master %0d got no r_valid one cycle after its grant, entry %0d",
                             m, first + k);
                    stop_with_failure();
                end else if (!granted[k] && mst_rsp[m].r_valid) begin
                    $display("Master %0d saw r_valid before its grant, entry %0d", m, first + k);
                    stop_with_failure();
                end
                if (!granted[k] && mst_rsp[m].gnt) begin
                    granted[k]   = 1'b1;
                    gnt_cycle[k] = cycles;
                end
            end
            // Round robin serves every contender within NR_MASTERS grants
            if (count > 1 && granted != all_mask && cycles >= NR_MASTERS) begin
                $display("Group at entry %0d not fully granted within %0d cycles",
                         first, NR_MASTERS);
                stop_with_failure();
            end
            @(posedge clk);
            #(DRIVE_DLY);
            for (int k = 0; k < count; k++) begin
                if (granted[k]) begin
                    mst_req[int'(STIM_TABLE[first + k].master)] = '0;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        int idx;
        clk         = 1'b0;
        reset       = 1'b1;
        error_count = 0;
        for (int m = 0; m < NR_MASTERS; m++) begin
            mst_req[m] = '0;
        end
        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        reset = 1'b0;
        check_bus_idle(3);
        idx = 0;
        while (idx < NR_ENTRIES) begin
            if (STIM_TABLE[idx].grp) begin
                run_batch(idx, NR_MASTERS);
                idx += NR_MASTERS;
            end else begin
                run_batch(idx, 1);
                idx++;
            end
        end
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Bound on the whole run from the table length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== list.f ====
rtl/soc_ic_pkg.sv
rtl/tcdm_master_port.sv
rtl/tcdm_rr_arbiter.sv
rtl/l2_sram_bank.sv
rtl/apb_master_bridge.sv
rtl/soc_interconnect_top.sv
bench/apb_periph_model.sv
bench/tb_soc_interconnect.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f \
        --top-module tb_soc_interconnect -o sim_soc_ic; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_soc_ic 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
